//--- design/mips16_cfg.svh
`ifndef MIPS16_CFG_SVH
`define MIPS16_CFG_SVH

// core datapath widths
`define MIPS16_DATA_W   16  // data word and instruction word
`define MIPS16_RADDR_W  3   // eight registers
`define MIPS16_PC_W     8   // 256-word instruction space

// instruction fields
`define MIPS16_IMM_W    6   // signed immediate, also the branch offset
`define MIPS16_OP_W     4   // opcode in bits 15..12

// data memory
`define MIPS16_DMEM_AW  8   // 256 words, low bits of the alu result

`endif

//--- design/mips16_pkg.sv
`include "mips16_cfg.svh"

package mips16_pkg;

	typedef logic [`MIPS16_DATA_W-1:0]  word_t;
	typedef logic [`MIPS16_RADDR_W-1:0] raddr_t;
	typedef logic [`MIPS16_PC_W-1:0]    pc_t;
	typedef logic [`MIPS16_IMM_W-1:0]   imm_t;

	// codes 13..15 decode as nop
	typedef enum logic [`MIPS16_OP_W-1:0] {
		OP_NOP = 0,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRA,
		OP_SRL,
		OP_ADDI,
		OP_LD,
		OP_ST,
		OP_BZ
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRA,
		ALU_SRL
	} alu_cmd_e;

	// 57 bits, decode to execute
	typedef struct packed {
		alu_cmd_e alu_cmd;
		word_t    src_a;
		word_t    src_b;      // register or sign-extended imm
		logic     mem_we;
		word_t    store_data;
		logic     wb_en;
		raddr_t   wb_dest;    // 0 for st, bz, nop, bubbles
		logic     wb_from_mem;
	} id_ex_t;

	// 38 bits, execute to memory
	typedef struct packed {
		word_t  alu_result;
		logic   mem_we;
		word_t  store_data;
		logic   wb_en;
		raddr_t wb_dest;
		logic   wb_from_mem;
	} ex_mem_t;

	// 37 bits, memory to writeback
	typedef struct packed {
		word_t  alu_result;
		word_t  load_data;
		logic   wb_en;
		raddr_t wb_dest;
		logic   wb_from_mem;
	} mem_wb_t;

endpackage

//--- design/regfile_rd_if.sv
`timescale 1ns/1ps

// two combinational read ports, same-cycle data
interface regfile_rd_if;
	import mips16_pkg::*;

	raddr_t addr1;
	raddr_t addr2; // src2, or the dest field for st
	word_t  data1;
	word_t  data2;

	modport decode (
		output addr1,
		output addr2,
		input  data1,
		input  data2
	);

	modport regfile (
		input  addr1,
		input  addr2,
		output data1,
		output data2
	);

endinterface

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "mips16_cfg.svh"

module fetch_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  logic               branch_taken,
	input  mips16_pkg::imm_t   branch_offset,
	input  logic               prog_we,
	input  mips16_pkg::pc_t    prog_addr,
	input  mips16_pkg::word_t  prog_data,
	output mips16_pkg::pc_t    pc,
	output mips16_pkg::word_t  instr
);
	import mips16_pkg::*;

	localparam int IMEM_DEPTH = 1 << `MIPS16_PC_W;
	localparam int EXT_W      = `MIPS16_PC_W - `MIPS16_IMM_W;

	word_t imem [IMEM_DEPTH];
	pc_t   offset_ext;

	// program load port, only used while the core sits in reset
	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	assign instr = imem[pc]; // async read

	// pc already points past the bz, so target is bz + 1 + offset
	assign offset_ext = {{EXT_W{branch_offset[`MIPS16_IMM_W-1]}}, branch_offset};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			if (branch_taken)
				pc <= pc + offset_ext; // wraps in 256 words
			else
				pc <= pc + 1'b1;
		end
	end

	// fetch freezes for the whole stall
	a_pc_hold: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc));

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "mips16_cfg.svh"

module decode_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  mips16_pkg::word_t   instr,
	regfile_rd_if.decode        rd,
	output mips16_pkg::id_ex_t  id_ex,
	output logic                branch_taken,
	output mips16_pkg::imm_t    branch_offset,
	output mips16_pkg::raddr_t  src1,
	output mips16_pkg::raddr_t  src2
);
	import mips16_pkg::*;

	localparam int EXT_W = `MIPS16_DATA_W - `MIPS16_IMM_W;

	word_t    ir;
	opcode_e  op;
	raddr_t   ir_dest;
	raddr_t   ir_src1;
	raddr_t   ir_src2;
	imm_t     ir_imm;
	word_t    imm_ext;
	alu_cmd_e alu_cmd;
	logic     use_imm;
	logic     is_store;
	logic     is_branch;
	logic     wb_en;
	logic     wb_from_mem;
	logic     no_src2;     // addi, ld, bz read only src1
	id_ex_t   id_ex_d;

	// instruction register, frozen during a stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ir <= '0;
		end else if (!stall) begin
			ir <= instr;
		end
	end

	assign op      = opcode_e'(ir[15:12]);
	assign ir_dest = ir[11:9];
	assign ir_src1 = ir[8:6];
	assign ir_src2 = ir[5:3];
	assign ir_imm  = ir[5:0];
	assign imm_ext = {{EXT_W{ir_imm[`MIPS16_IMM_W-1]}}, ir_imm};

	always_comb begin
		case (op)
			OP_SUB:  alu_cmd = ALU_SUB;
			OP_AND:  alu_cmd = ALU_AND;
			OP_OR:   alu_cmd = ALU_OR;
			OP_XOR:  alu_cmd = ALU_XOR;
			OP_SLL:  alu_cmd = ALU_SLL;
			OP_SRA:  alu_cmd = ALU_SRA;
			OP_SRL:  alu_cmd = ALU_SRL;
			default: alu_cmd = ALU_ADD; // add, addi and the ld/st address
		endcase
	end

	always_comb begin
		use_imm     = 1'b0;
		is_store    = 1'b0;
		is_branch   = 1'b0;
		wb_en       = 1'b0;
		wb_from_mem = 1'b0;
		no_src2     = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRA, OP_SRL: wb_en = 1'b1;
			OP_ADDI: begin
				wb_en   = 1'b1;
				use_imm = 1'b1;
				no_src2 = 1'b1;
			end
			OP_LD: begin
				wb_en       = 1'b1;
				use_imm     = 1'b1;
				wb_from_mem = 1'b1;
				no_src2     = 1'b1;
			end
			OP_ST: begin
				use_imm  = 1'b1;
				is_store = 1'b1;
			end
			OP_BZ: begin
				is_branch = 1'b1;
				no_src2   = 1'b1;
			end
			default: ; // nop and codes 13..15
		endcase
	end

	// st reads its data register through port 2
	assign rd.addr1 = ir_src1;
	assign rd.addr2 = is_store ? ir_dest : ir_src2;

	assign src1 = ir_src1;
	assign src2 = no_src2 ? '0 : rd.addr2;

	// bz only taken with a zero dest field
	assign branch_taken  = is_branch && (ir_dest == '0) && (rd.data1 == '0);
	assign branch_offset = ir_imm;

	always_comb begin
		if (stall) begin
			id_ex_d = '0; // bubble
		end else begin
			id_ex_d.alu_cmd     = alu_cmd;
			id_ex_d.src_a       = rd.data1;
			id_ex_d.src_b       = use_imm ? imm_ext : rd.data2;
			id_ex_d.mem_we      = is_store;
			id_ex_d.store_data  = rd.data2;
			id_ex_d.wb_en       = wb_en;
			id_ex_d.wb_dest     = wb_en ? ir_dest : '0; // non-writers never stall anyone
			id_ex_d.wb_from_mem = wb_from_mem;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			id_ex <= '0;
		else
			id_ex <= id_ex_d;
	end

	// a stalled edge must leave a harmless bubble in execute
	a_bubble: assert property (@(posedge clk) disable iff (rst)
		stall |=> !id_ex.wb_en && !id_ex.mem_we && (id_ex.wb_dest == '0));

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "mips16_cfg.svh"

module execute_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  mips16_pkg::id_ex_t   id_ex,
	output mips16_pkg::ex_mem_t  ex_mem
);
	import mips16_pkg::*;

	localparam int SHAMT_W = $clog2(`MIPS16_DATA_W);

	word_t a;
	word_t b;
	word_t alu_y;
	logic  shift_big;

	assign a = id_ex.src_a;
	assign b = id_ex.src_b;

	// whole of b is the shift amount
	assign shift_big = (b >= `MIPS16_DATA_W);

	always_comb begin
		case (id_ex.alu_cmd)
			ALU_ADD: alu_y = a + b;
			ALU_SUB: alu_y = a - b;
			ALU_AND: alu_y = a & b;
			ALU_OR:  alu_y = a | b;
			ALU_XOR: alu_y = a ^ b;
			ALU_SLL: alu_y = shift_big ? '0 : a << b[SHAMT_W-1:0];
			ALU_SRA: alu_y = shift_big ? {`MIPS16_DATA_W{a[`MIPS16_DATA_W-1]}}
			                           : word_t'($signed(a) >>> b[SHAMT_W-1:0]);
			ALU_SRL: alu_y = shift_big ? '0 : a >> b[SHAMT_W-1:0];
			default: alu_y = '0;
		endcase
	end

	// EX/MEM, control fields ride along unchanged
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_mem <= '0;
		end else begin
			ex_mem.alu_result  <= alu_y;
			ex_mem.mem_we      <= id_ex.mem_we;
			ex_mem.store_data  <= id_ex.store_data;
			ex_mem.wb_en       <= id_ex.wb_en;
			ex_mem.wb_dest     <= id_ex.wb_dest;
			ex_mem.wb_from_mem <= id_ex.wb_from_mem;
		end
	end

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ps
`include "mips16_cfg.svh"

module memory_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  mips16_pkg::ex_mem_t  ex_mem,
	output logic                 wb_en,
	output mips16_pkg::raddr_t   wb_dest,
	output mips16_pkg::word_t    wb_data
);
	import mips16_pkg::*;

	localparam int DMEM_DEPTH = 1 << `MIPS16_DMEM_AW;

	word_t                     dmem [DMEM_DEPTH];
	logic [`MIPS16_DMEM_AW-1:0] dmem_addr;
	word_t                     load_data;
	mem_wb_t                   mem_wb;

	assign dmem_addr = ex_mem.alu_result[`MIPS16_DMEM_AW-1:0]; // wraps mod 256

	// store lands at the end of the memory cycle
	always_ff @(posedge clk) begin
		if (ex_mem.mem_we) begin
			dmem[dmem_addr] <= ex_mem.store_data;
		end
	end

	assign load_data = dmem[dmem_addr]; // async read, same cycle

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_wb <= '0;
		end else begin
			mem_wb.alu_result  <= ex_mem.alu_result;
			mem_wb.load_data   <= load_data;
			mem_wb.wb_en       <= ex_mem.wb_en;
			mem_wb.wb_dest     <= ex_mem.wb_dest;
			mem_wb.wb_from_mem <= ex_mem.wb_from_mem;
		end
	end

	// writeback bus, also feeds the register file and hazard unit
	assign wb_en   = mem_wb.wb_en;
	assign wb_dest = mem_wb.wb_dest;
	assign wb_data = mem_wb.wb_from_mem ? mem_wb.load_data : mem_wb.alu_result;

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps
`include "mips16_cfg.svh"

module register_file (
	input  logic                clk,
	input  logic                rst,
	input  logic                wb_en,
	input  mips16_pkg::raddr_t  wb_dest,
	input  mips16_pkg::word_t   wb_data,
	regfile_rd_if.regfile       rd
);
	import mips16_pkg::*;

	localparam int NUM_REGS = 1 << `MIPS16_RADDR_W;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_dest] <= wb_data; // r0 may be written, masked on read
		end
	end

	assign rd.data1 = (rd.addr1 == '0) ? '0 : regs[rd.addr1];
	assign rd.data2 = (rd.addr2 == '0) ? '0 : regs[rd.addr2];

	// a retired write to r0 must stay invisible to decode
	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		(wb_en && wb_dest == '0) |=>
			(rd.addr1 != '0 || rd.data1 == '0) && (rd.addr2 != '0 || rd.data2 == '0));

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  mips16_pkg::raddr_t  src1,
	input  mips16_pkg::raddr_t  src2,
	input  mips16_pkg::raddr_t  ex_dest,
	input  mips16_pkg::raddr_t  mem_dest,
	input  mips16_pkg::raddr_t  wb_dest,
	output logic                stall
);
	import mips16_pkg::*;

	// source still in flight in ex, mem or wb
	function automatic logic raw_hit(input raddr_t src);
		return (src != '0) && (src == ex_dest || src == mem_dest || src == wb_dest);
	endfunction

	// no forwarding, so wait until the writer has left writeback
	assign stall = raw_hit(src1) || raw_hit(src2);

	always_comb begin
		if (src1 == '0 && src2 == '0)
			a_no_src_stall: assert (!stall);
	end

endmodule

//--- design/mips16_core.sv
`timescale 1ns/1ps

module mips16_core (
	input  logic                clk,
	input  logic                rst,
	input  logic                prog_we,
	input  mips16_pkg::pc_t     prog_addr,
	input  mips16_pkg::word_t   prog_data,
	output mips16_pkg::pc_t     pc,
	output logic                wb_en,
	output mips16_pkg::raddr_t  wb_dest,
	output mips16_pkg::word_t   wb_data
);
	import mips16_pkg::*;

	logic    stall;
	logic    branch_taken;
	imm_t    branch_offset;
	word_t   instr;
	raddr_t  src1;
	raddr_t  src2;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;

	regfile_rd_if rd_if ();

	fetch_stage fetch_i (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_offset (branch_offset),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.pc            (pc),
		.instr         (instr)
	);

	decode_stage decode_i (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.instr         (instr),
		.rd            (rd_if.decode),
		.id_ex         (id_ex),
		.branch_taken  (branch_taken),
		.branch_offset (branch_offset),
		.src1          (src1),
		.src2          (src2)
	);

	execute_stage execute_i (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	memory_stage memory_i (
		.clk     (clk),
		.rst     (rst),
		.ex_mem  (ex_mem),
		.wb_en   (wb_en),
		.wb_dest (wb_dest),
		.wb_data (wb_data)
	);

	register_file regfile_i (
		.clk     (clk),
		.rst     (rst),
		.wb_en   (wb_en),
		.wb_dest (wb_dest),
		.wb_data (wb_data),
		.rd      (rd_if.regfile)
	);

	// destinations of the three younger stages
	hazard_unit hazard_i (
		.src1     (src1),
		.src2     (src2),
		.ex_dest  (id_ex.wb_dest),
		.mem_dest (ex_mem.wb_dest),
		.wb_dest  (wb_dest),
		.stall    (stall)
	);

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/1ps

// free-running testbench clock plus power-on reset
module clk_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b0; // release off the edge
	end

endmodule

//--- dv/mips16_tb.sv
`timescale 1ns/1ps

module mips16_tb;
	import mips16_pkg::*;

	logic   clk;
	logic   por_rst;
	logic   load_rst;   // held while a program is written
	logic   rst;
	logic   prog_we;
	pc_t    prog_addr;
	word_t  prog_data;
	pc_t    pc;
	logic   wb_en;
	raddr_t wb_dest;
	word_t  wb_data;

	word_t  prog [256];
	int     prog_len;
	word_t  model_mem [256];  // persists across tests like the DUT RAM
	int     exp_dest [$];
	word_t  exp_data [$];
	logic [31:0] lcg_state = 32'd88733;
	logic   checking = 1'b0;
	int     errors = 0;
	int     test_errs;
	int     test_writes;
	int     tests_run = 0;
	int     budget = 100;     // cycles, grows with each program
	int     cycles = 0;

	assign rst = por_rst | load_rst;

	clk_gen clk_i (.clk(clk), .rst(por_rst));

	mips16_core dut_i (
		.clk       (clk),
		.rst       (rst),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.pc        (pc),
		.wb_en     (wb_en),
		.wb_dest   (wb_dest),
		.wb_data   (wb_data)
	);

	function automatic int lcg();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]);
	endfunction

	function automatic word_t enc_r(int op, int d, int s1, int s2);
		return {op[3:0], d[2:0], s1[2:0], s2[2:0], 3'b000};
	endfunction

	function automatic word_t enc_i(int op, int d, int s1, int imm);
		return {op[3:0], d[2:0], s1[2:0], imm[5:0]};
	endfunction

	function automatic void emit(word_t w);
		prog[prog_len] = w;
		prog_len++;
	endfunction

	// self-loop bz then its delay-slot nop
	function automatic void end_prog();
		emit(enc_i(OP_BZ, 0, 0, -1));
		emit(16'h0000);
	endfunction

	// instruction-set model with one delay slot, fills the expected write list
	function automatic void run_model();
		word_t regs [8];
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		word_t r;
		word_t ea;
		int    cur;
		int    nxt;
		int    after;
		int    steps;
		int    op;
		int    d;
		logic  wr;
		logic  taken;
		exp_dest.delete();
		exp_data.delete();
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		cur = 0;
		nxt = 1;
		steps = 0;
		while (cur != prog_len - 2 && steps < 4000) begin
			ins = prog[cur];
			op = int'(ins[15:12]);
			d = int'(ins[11:9]);
			a = (ins[8:6] == 3'd0) ? 16'h0 : regs[ins[8:6]]; // r0 reads zero
			b = (ins[5:3] == 3'd0) ? 16'h0 : regs[ins[5:3]];
			imm = {{10{ins[5]}}, ins[5:0]};
			ea = a + imm;
			r = '0;
			wr = 1'b1;
			taken = 1'b0;
			case (op)
				OP_ADD:  r = a + b;
				OP_SUB:  r = a - b;
				OP_AND:  r = a & b;
				OP_OR:   r = a | b;
				OP_XOR:  r = a ^ b;
				OP_SLL:  r = (b >= 16'd16) ? 16'h0 : a << b[3:0];
				OP_SRL:  r = (b >= 16'd16) ? 16'h0 : a >> b[3:0];
				OP_SRA: begin
					r = a;
					for (int k = 0; k < 16; k++) // one bit at a time, sign fill
						if (k < b)
							r = {a[15], r[15:1]};
				end
				OP_ADDI: r = ea;
				OP_LD:   r = model_mem[ea[7:0]];
				OP_ST: begin
					wr = 1'b0;
					model_mem[ea[7:0]] = (d == 0) ? 16'h0 : regs[d];
				end
				OP_BZ: begin
					wr = 1'b0;
					taken = (d == 0) && (a == 16'h0);
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				exp_dest.push_back(d);
				exp_data.push_back(r);
				regs[d] = r;
			end
			after = taken ? ((cur + 1 + int'($signed(ins[5:0]))) & 255) : ((nxt + 1) & 255);
			cur = nxt;
			nxt = after;
			steps++;
		end
	endfunction

	task automatic check_val(string what, word_t got, word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	// compare every retired write, sampled mid-cycle
	always @(negedge clk) begin
		if (checking && !rst && wb_en) begin
			if (exp_dest.size() == 0) begin
				$display("extra register write r%0d = %h after the last expected one",
					wb_dest, wb_data);
				errors++;
				test_errs++;
			end else begin
				check_val("wb_dest", word_t'(wb_dest), word_t'(exp_dest[0]));
				check_val("wb_data", wb_data, exp_data[0]);
				void'(exp_dest.pop_front());
				void'(exp_data.pop_front());
				test_writes++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("timeout, the run went past its cycle budget");
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic run_test(string name);
		int waited;
		pc_t pc_a;
		pc_t pc_b;
		budget += 80 * prog_len;
		test_errs = 0;
		test_writes = 0;
		@(posedge clk);
		#2 load_rst = 1'b1;
		for (int i = 0; i < prog_len; i++) begin
			@(posedge clk);
			#2;
			prog_we = 1'b1;
			prog_addr = pc_t'(i);
			prog_data = prog[i];
		end
		@(posedge clk);
		#2 prog_we = 1'b0;
		run_model();
		checking = 1'b1;
		@(posedge clk);
		#2 load_rst = 1'b0;
		waited = 0;
		while (exp_dest.size() != 0 && waited < 80 * prog_len) begin
			@(posedge clk);
			waited++;
		end
		if (exp_dest.size() != 0) begin
			$display("%s: %0d expected writes never arrived", name, exp_dest.size());
			errors++;
			test_errs++;
		end
		repeat (50) @(posedge clk); // extra writes show up here
		checking = 1'b0;
		// parked in the final self-loop, pc toggles between bz and its slot
		@(negedge clk);
		pc_a = pc;
		@(negedge clk);
		pc_b = pc;
		check_val("pc low", word_t'((pc_a < pc_b) ? pc_a : pc_b), word_t'(prog_len - 2));
		check_val("pc high", word_t'((pc_a < pc_b) ? pc_b : pc_a), word_t'(prog_len - 1));
		tests_run++;
		$display("%s: %0d writes checked, %0d errors", name, test_writes, test_errs);
	endtask

	initial begin
		load_rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		@(negedge por_rst);

		// negative r1, positive r2, shift amounts below and above 16
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, -(lcg() % 32) - 1));
		emit(enc_i(OP_ADDI, 3, 0, 1 + lcg() % 9));
		emit(enc_r(OP_SLL, 1, 1, 3));
		emit(enc_i(OP_ADDI, 4, 0, lcg() % 64));
		emit(enc_r(OP_OR, 1, 1, 4));
		emit(enc_i(OP_ADDI, 2, 0, lcg() % 32));
		emit(enc_i(OP_ADDI, 3, 0, 4));
		emit(enc_r(OP_SLL, 2, 2, 3));
		emit(enc_i(OP_ADDI, 4, 0, lcg() % 32));
		emit(enc_r(OP_OR, 2, 2, 4));
		emit(enc_i(OP_ADDI, 5, 0, lcg() % 16));
		emit(enc_i(OP_ADDI, 6, 0, 16 + lcg() % 16));
		for (int op = OP_ADD; op <= OP_SRL; op++)
			emit(enc_r(op, 7, 1, 2));
		for (int op = OP_SLL; op <= OP_SRL; op++) begin
			emit(enc_r(op, 7, 1, 5));
			emit(enc_r(op, 7, 1, 6));
		end
		end_prog();
		run_test("alu_ops");

		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, -32));
		emit(enc_i(OP_ADDI, 2, 1, -1));
		emit(enc_i(OP_ADDI, 0, 0, 17));   // shows on the bus only
		emit(enc_r(OP_ADD, 3, 0, 1));
		emit(enc_i(OP_ADDI, 4, 0, 0));
		emit(enc_r(OP_SUB, 5, 0, 2));
		end_prog();
		run_test("addi_r0");

		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 3));
		emit(enc_r(OP_ADD, 2, 1, 1));
		emit(enc_r(OP_SUB, 3, 2, 1));
		emit(enc_r(OP_XOR, 4, 3, 2));
		emit(enc_r(OP_SLL, 5, 4, 1));
		emit(enc_r(OP_SRA, 6, 5, 3));
		emit(enc_r(OP_AND, 7, 6, 5));
		emit(enc_r(OP_OR, 1, 7, 2));
		end_prog();
		run_test("dependent_chain");

		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 20));
		emit(enc_i(OP_ADDI, 2, 0, -7));
		emit(enc_i(OP_ST, 2, 1, 0));
		emit(enc_i(OP_LD, 3, 1, 0));
		emit(enc_i(OP_ADDI, 4, 0, 13));
		emit(enc_i(OP_ST, 4, 1, 5));
		emit(enc_i(OP_LD, 5, 1, 5));
		emit(enc_i(OP_LD, 6, 1, 0));
		emit(enc_i(OP_ADDI, 1, 0, -1));
		emit(enc_i(OP_ST, 2, 1, 3));      // 0xffff + 3 lands on word 2
		emit(enc_i(OP_LD, 7, 0, 2));
		end_prog();
		run_test("store_load");

		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 1));
		emit(enc_i(OP_BZ, 0, 0, 2));      // forward, skips one
		emit(enc_i(OP_ADDI, 2, 0, 5));    // delay slot
		emit(enc_i(OP_ADDI, 3, 0, 7));
		emit(enc_i(OP_ADDI, 3, 0, 9));
		emit(enc_i(OP_ADDI, 4, 0, -1));
		emit(enc_i(OP_ADDI, 4, 4, 1));
		emit(enc_i(OP_BZ, 0, 4, -2));     // back once, then falls through
		emit(enc_i(OP_ADDI, 7, 7, 1));
		emit(enc_i(OP_BZ, 1, 0, 2));      // nonzero dest field, not taken
		emit(enc_i(OP_ADDI, 5, 0, 11));
		emit(enc_i(OP_ADDI, 6, 0, 12));
		end_prog();
		run_test("branches");

		prog_len = 0;
		for (int i = 0; i < 40; i++) begin
			int op;
			op = lcg() % 12; // nop through st, never bz
			if (op >= OP_ADDI)
				emit(enc_i(op, lcg() % 8, lcg() % 8, lcg() % 64));
			else
				emit(enc_r(op, lcg() % 8, lcg() % 8, lcg() % 8));
		end
		end_prog();
		run_test("random_program");

		$display("%0d tests, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+design
design/mips16_pkg.sv
design/regfile_rd_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/register_file.sv
design/hazard_unit.sv
design/mips16_core.sv
dv/clk_gen.sv
dv/mips16_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mips16_tb -f flist.f -o Vmips16_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vmips16_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
